/* logic/simd_mult_pkg.sv */
package simd_mult_pkg;

    // widths
    localparam int unsigned arch_width = 32;
    localparam int unsigned arch_width_h = 16;
    localparam int unsigned arch_width_d = 64;

    // packed lane sizes
    localparam int unsigned lane_8 = 8;
    localparam int unsigned lane_16 = 16;

    // dot8 sum carries 17 meaningful bits before sign extension
    localparam int unsigned dot8_w = arch_width_h + 1;

    typedef logic [arch_width-1:0] simd_t;     // operand, accumulator, result
    typedef logic [arch_width_d-1:0] simd_d_t; // partial product / tree word

    // bit 2 set means a packed (dot product) operation
    typedef enum logic [2:0] {
        MULT_OP_MUL = 3'd0,
        MULT_OP_MULH = 3'd1,
        MULT_OP_MULHSU = 3'd2,
        MULT_OP_MULHU = 3'd3,
        MULT_OP_DOT16 = 3'd4,
        MULT_OP_DOT8 = 3'd5
    } mult_op_t;

    typedef struct packed {
        logic flush;  // stage loads reset value
        logic bubble; // nothing entered, load reset value
    } stage_ctrl_t;

    // reset values
    localparam mult_op_t op_rst = MULT_OP_MUL;
    localparam simd_t word_rst = '0;
    localparam simd_d_t dword_rst = '0;
    localparam logic valid_rst = 1'b0;

endpackage

/* logic/mult_stage_if.sv */
`timescale 1ns/100ps

interface mult_stage_if;

    logic en;                            // stage advance
    simd_mult_pkg::stage_ctrl_t ctrl;
    simd_mult_pkg::mult_op_t op;
    simd_mult_pkg::simd_t a;
    simd_mult_pkg::simd_t b;
    simd_mult_pkg::simd_t c_late;        // used in the result cycle

    modport ctrl_mp (
        output en, ctrl, op, a, b, c_late
    );

    modport core_mp (
        input en, ctrl, op, a, b, c_late
    );

endinterface

/* logic/csa.sv */
`timescale 1ns/100ps

module csa #(
    parameter int unsigned W = 64
) (
    input  logic [W-1:0] x,
    input  logic [W-1:0] y,
    input  logic [W-1:0] z,
    output logic [W-1:0] s,
    output logic [W-1:0] c
);

// carry stays at its own bit position, caller shifts it
assign s = x ^ y ^ z;
assign c = (x & y) | (x & z) | (y & z);

endmodule

/* logic/csa_tree_8.sv */
`timescale 1ns/100ps

module csa_tree_8 #(
    parameter int unsigned W = 64
) (
    input  logic [7:0][W-1:0] a,
    output logic [1:0][W-1:0] o  // [0] sum, [1] carry (aligned)
);

logic [W-1:0] s0, c0, s1, c1; // level 1
logic [W-1:0] s2, c2, s3, c3; // level 2
logic [W-1:0] s4, c4, s5, c5; // level 3

// 8 rows -> 6
csa #(.W(W)) csa_l1_0 (.x(a[0]), .y(a[1]), .z(a[2]), .s(s0), .c(c0));
csa #(.W(W)) csa_l1_1 (.x(a[3]), .y(a[4]), .z(a[5]), .s(s1), .c(c1));

// 6 rows -> 4
csa #(.W(W)) csa_l2_0 (
    .x(s0),
    .y(c0 << 1),
    .z(s1),
    .s(s2),
    .c(c2)
);
csa #(.W(W)) csa_l2_1 (
    .x(c1 << 1),
    .y(a[6]),
    .z(a[7]),
    .s(s3),
    .c(c3)
);

// 4 rows -> 3 -> 2
csa #(.W(W)) csa_l3_0 (
    .x(s2),
    .y(c2 << 1),
    .z(s3),
    .s(s4),
    .c(c4)
);
csa #(.W(W)) csa_l3_1 (
    .x(s4),
    .y(c4 << 1),
    .z(c3 << 1),
    .s(s5),
    .c(c5)
);

assign o[0] = s5;
assign o[1] = c5 << 1; // sum of outputs equals sum of inputs mod 2^W

endmodule

/* logic/simd_mult_core.sv */
`timescale 1ns/100ps

module simd_mult_core (
    input  logic i_clk,
    input  logic i_reset,
    mult_stage_if.core_mp st,
    output simd_mult_pkg::simd_t o_p
);

// one partial-product row, lane-aware modified Baugh-Wooley
// row i is a[i] against all of b, masked to its diagonal tile,
// shifted to its weight and moved back down so each lane starts at bit 0
function automatic simd_mult_pkg::simd_d_t pp_row(
    input simd_mult_pkg::simd_t a,
    input simd_mult_pkg::simd_t b,
    input int unsigned i,
    input int unsigned lane,
    input logic sgn
);
    simd_mult_pkg::simd_t row;
    simd_mult_pkg::simd_d_t wide;
    int unsigned li;
    int unsigned lj;
    logic t;
    li = i % lane;
    for (int unsigned j = 0; j < simd_mult_pkg::arch_width; j++) begin
        lj = j % lane;
        t = a[i] & b[j];
        // flip last row and last col, sign x sign corner stays
        if (sgn && ((li == lane - 1) != (lj == lane - 1))) begin
            t = ~t;
        end
        row[j] = ((i / lane) == (j / lane)) ? t : 1'b0;
    end
    wide = {simd_mult_pkg::word_rst, row};
    return (wide << li) >> ((i / lane) * lane);
endfunction

logic op_dot16, op_dot8, op_simd;
assign op_dot16 = (st.op == simd_mult_pkg::MULT_OP_DOT16);
assign op_dot8 = (st.op == simd_mult_pkg::MULT_OP_DOT8);
assign op_simd = st.op[2];

simd_mult_pkg::simd_d_t [simd_mult_pkg::arch_width-1:0] ppv;
always_comb begin
    for (int unsigned i = 0; i < simd_mult_pkg::arch_width; i++) begin
        if (op_dot8) begin
            ppv[i] = pp_row(st.a, st.b, i, simd_mult_pkg::lane_8, 1'b1);
        end else if (op_dot16) begin
            ppv[i] = pp_row(st.a, st.b, i, simd_mult_pkg::lane_16, 1'b1);
        end else begin
            // MULHU is the only unsigned one
            ppv[i] = pp_row(st.a, st.b, i, simd_mult_pkg::arch_width,
                            (st.op != simd_mult_pkg::MULT_OP_MULHU));
        end
    end
end

// correction constant 2^n + 2^(2n-1) per lane, truncated to the kept bits
simd_mult_pkg::simd_d_t corr;
always_comb begin
    corr = simd_mult_pkg::dword_rst;
    if (!op_simd) begin
        corr[simd_mult_pkg::arch_width] = 1'b1;
        corr[simd_mult_pkg::arch_width_d-1] = 1'b1;
    end else if (op_dot16) begin
        corr[simd_mult_pkg::arch_width_h+1] = 1'b1; // 2 lanes x 2^16
    end else if (op_dot8) begin
        corr[simd_mult_pkg::lane_8+2] = 1'b1;       // 4 lanes x 2^8
    end
end

// first cycle: four trees of eight rows each
simd_mult_pkg::simd_d_t [7:0] tree_o;
for (genvar t = 0; t < 4; t++) begin : g_tree
    csa_tree_8 #(.W(simd_mult_pkg::arch_width_d)) csa_tree_8_i (
        .a(ppv[8*t+7:8*t]),
        .o(tree_o[2*t+1:2*t])
    );
end

// stage registers
simd_mult_pkg::simd_d_t [7:0] tree_d;
simd_mult_pkg::simd_d_t corr_d;
simd_mult_pkg::mult_op_t op_d;
simd_mult_pkg::simd_t a_d;
logic b_sign_d;

always_ff @(posedge i_clk) begin
    if (i_reset || st.ctrl.flush) begin
        tree_d <= {8{simd_mult_pkg::dword_rst}};
        corr_d <= simd_mult_pkg::dword_rst;
        op_d <= simd_mult_pkg::op_rst;
    end else if (st.en) begin
        if (st.ctrl.bubble) begin
            tree_d <= {8{simd_mult_pkg::dword_rst}};
            corr_d <= simd_mult_pkg::dword_rst;
            op_d <= simd_mult_pkg::op_rst;
        end else begin
            tree_d <= tree_o;
            corr_d <= corr;
            op_d <= st.op;
        end
    end
end

// a and b sign only matter for MULHSU
always_ff @(posedge i_clk) begin
    if (i_reset || st.ctrl.flush) begin
        a_d <= simd_mult_pkg::word_rst;
        b_sign_d <= 1'b0;
    end else if (st.en && !op_simd) begin
        if (st.ctrl.bubble) begin
            a_d <= simd_mult_pkg::word_rst;
            b_sign_d <= 1'b0;
        end else begin
            a_d <= st.a;
            b_sign_d <= st.b[simd_mult_pkg::arch_width-1];
        end
    end
end

// second cycle: final tree
simd_mult_pkg::simd_d_t [1:0] tree_f;
simd_mult_pkg::simd_d_t tree_sum;
csa_tree_8 #(.W(simd_mult_pkg::arch_width_d)) csa_tree_8_f_i (
    .a(tree_d),
    .o(tree_f)
);
assign tree_sum = tree_f[0] + tree_f[1]; // uncorrected, unsigned product

// signed product with correction
simd_mult_pkg::simd_d_t mul_s_sum, mul_s_cy, mul_s_cy_al, mul_s;
csa #(.W(simd_mult_pkg::arch_width_d)) csa_i_mul_s (
    .x(tree_f[0]),
    .y(tree_f[1]),
    .z(corr_d),
    .s(mul_s_sum),
    .c(mul_s_cy)
);
assign mul_s_cy_al = mul_s_cy << 1;
assign mul_s = mul_s_sum + mul_s_cy_al;

// negative b read as unsigned adds a * 2^32
simd_mult_pkg::simd_d_t mul_hsu_sum, mul_hsu_cy, mul_hsu_full;
csa #(.W(simd_mult_pkg::arch_width_d)) csa_i_mul_hsu (
    .x(mul_s_sum),
    .y(mul_s_cy_al),
    .z({a_d, simd_mult_pkg::word_rst}),
    .s(mul_hsu_sum),
    .c(mul_hsu_cy)
);
assign mul_hsu_full = mul_hsu_sum + (mul_hsu_cy << 1);

simd_mult_pkg::simd_t mul_hi, mul_hsu, mul_hu;
assign mul_hi = mul_s[simd_mult_pkg::arch_width_d-1:simd_mult_pkg::arch_width];
assign mul_hu = tree_sum[simd_mult_pkg::arch_width_d-1:simd_mult_pkg::arch_width];
assign mul_hsu = b_sign_d ?
    mul_hsu_full[simd_mult_pkg::arch_width_d-1:simd_mult_pkg::arch_width] : mul_hi;

// dot sums plus late accumulator
simd_mult_pkg::simd_t dot_r, dot8_r, dot_in;
assign dot_r = mul_s[simd_mult_pkg::arch_width-1:0];
assign dot8_r = {{(simd_mult_pkg::arch_width - simd_mult_pkg::dot8_w)
                  {dot_r[simd_mult_pkg::dot8_w-1]}},
                 dot_r[simd_mult_pkg::dot8_w-1:0]};
assign dot_in = (op_d == simd_mult_pkg::MULT_OP_DOT16) ? dot_r : dot8_r;

always_comb begin
    case (op_d)
        simd_mult_pkg::MULT_OP_MUL: o_p = mul_s[simd_mult_pkg::arch_width-1:0];
        simd_mult_pkg::MULT_OP_MULH: o_p = mul_hi;
        simd_mult_pkg::MULT_OP_MULHSU: o_p = mul_hsu;
        simd_mult_pkg::MULT_OP_MULHU: o_p = mul_hu;
        simd_mult_pkg::MULT_OP_DOT16,
        simd_mult_pkg::MULT_OP_DOT8: o_p = dot_in + st.c_late;
        default: o_p = simd_mult_pkg::word_rst;
    endcase
end

endmodule

/* logic/mult_stage_ctrl.sv */
`timescale 1ns/100ps

module mult_stage_ctrl (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_valid,
    input  logic i_stall,
    input  logic i_flush,
    input  simd_mult_pkg::mult_op_t i_op,
    input  simd_mult_pkg::simd_t i_a,
    input  simd_mult_pkg::simd_t i_b,
    input  simd_mult_pkg::simd_t i_c_late,
    output logic o_valid,
    mult_stage_if.ctrl_mp st
);

logic en;
simd_mult_pkg::stage_ctrl_t ctrl;

// stage control from the issue levels
assign en = ~i_stall;
assign ctrl.bubble = ~i_valid; // nothing issued this cycle
assign ctrl.flush = i_flush;

assign st.en = en;
assign st.ctrl = ctrl;

// operation bundle goes straight through to the core
assign st.op = i_op;
assign st.a = i_a;
assign st.b = i_b;
assign st.c_late = i_c_late; // result cycle value

// result stage valid, same rule as the core registers
logic valid_q;
always_ff @(posedge i_clk) begin
    if (i_reset || ctrl.flush) begin
        valid_q <= simd_mult_pkg::valid_rst;
    end else if (en) begin
        if (ctrl.bubble) begin
            valid_q <= simd_mult_pkg::valid_rst;
        end else begin
            valid_q <= 1'b1;
        end
    end
end

assign o_valid = valid_q;

endmodule

/* logic/simd_mult_top.sv */
`timescale 1ns/100ps

module simd_mult_top (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_valid,
    input  logic i_stall,
    input  logic i_flush,
    input  simd_mult_pkg::mult_op_t i_op,
    input  simd_mult_pkg::simd_t i_a,
    input  simd_mult_pkg::simd_t i_b,
    input  simd_mult_pkg::simd_t i_c_late,
    output logic o_valid,
    output simd_mult_pkg::simd_t o_p
);

mult_stage_if st_if ();

mult_stage_ctrl mult_stage_ctrl_inst (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_valid(i_valid),
    .i_stall(i_stall),
    .i_flush(i_flush),
    .i_op(i_op),
    .i_a(i_a),
    .i_b(i_b),
    .i_c_late(i_c_late),
    .o_valid(o_valid),
    .st(st_if.ctrl_mp)
);

simd_mult_core simd_mult_core_inst (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .st(st_if.core_mp),
    .o_p(o_p)
);

endmodule

/* sim/simd_mult_tb.sv */
`timescale 1ns/100ps

module simd_mult_tb;

localparam int n_vec = 15;
localparam int n_rand = 200;
localparam int n_fields = 5;  // op, a, b, c_late, expected

logic clk;
logic i_reset;
logic i_valid;
logic i_stall;
logic i_flush;
simd_mult_pkg::mult_op_t i_op;
simd_mult_pkg::simd_t i_a;
simd_mult_pkg::simd_t i_b;
simd_mult_pkg::simd_t i_c_late;
logic o_valid;
simd_mult_pkg::simd_t o_p;

simd_mult_pkg::simd_t vec_mem [0:n_vec*n_fields-1];
simd_mult_pkg::simd_t exp_q[$];  // result due in the output cycle
simd_mult_pkg::simd_t c_q[$];    // its late accumulator
logic [31:0] rng_state;

simd_mult_top simd_mult_top_inst (
    .i_clk(clk),
    .i_reset(i_reset),
    .i_valid(i_valid),
    .i_stall(i_stall),
    .i_flush(i_flush),
    .i_op(i_op),
    .i_a(i_a),
    .i_b(i_b),
    .i_c_late(i_c_late),
    .o_valid(o_valid),
    .o_p(o_p)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

initial begin
    #((n_vec + n_rand + 50) * 10);
    $display("Timeout: the testbench did not reach its end in time");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
end

function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
endfunction

// plain arithmetic of each operation
function automatic simd_mult_pkg::simd_t ref_result(
    input simd_mult_pkg::mult_op_t op,
    input simd_mult_pkg::simd_t a,
    input simd_mult_pkg::simd_t b,
    input simd_mult_pkg::simd_t c
);
    logic [63:0] prod_ss;
    logic [63:0] prod_su;
    logic [63:0] prod_uu;
    logic [31:0] sum16;
    logic [31:0] sum8;
    simd_mult_pkg::simd_t res;
    prod_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    prod_su = {{32{a[31]}}, a} * {32'b0, b};
    prod_uu = {32'b0, a} * {32'b0, b};
    sum16 = '0;
    sum8 = '0;
    for (int k = 0; k < 2; k++) begin
        sum16 = sum16 + {{16{a[16*k+15]}}, a[16*k +: 16]} * {{16{b[16*k+15]}}, b[16*k +: 16]};
    end
    for (int k = 0; k < 4; k++) begin
        sum8 = sum8 + {{24{a[8*k+7]}}, a[8*k +: 8]} * {{24{b[8*k+7]}}, b[8*k +: 8]};
    end
    case (op)
        simd_mult_pkg::MULT_OP_MUL: res = prod_ss[31:0];
        simd_mult_pkg::MULT_OP_MULH: res = prod_ss[63:32];
        simd_mult_pkg::MULT_OP_MULHSU: res = prod_su[63:32];
        simd_mult_pkg::MULT_OP_MULHU: res = prod_uu[63:32];
        simd_mult_pkg::MULT_OP_DOT16: res = sum16 + c;
        default: res = {{15{sum8[16]}}, sum8[16:0]} + c;  // 17 bit dot8 sum
    endcase
    return res;
endfunction

task automatic check_result(input simd_mult_pkg::simd_t got, input simd_mult_pkg::simd_t exp);
    if (got !== exp) begin
        $display("Mismatch o_p: got %h, expected %h", got, exp);
        $display("Simulation failed");
        $fatal(1, "result check");
    end
endtask

task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
        $display("Mismatch o_valid: got %h, expected %h", got, exp);
        $display("Simulation failed");
        $fatal(1, "valid check");
    end
endtask

// drive at the falling edge then check and update the queues
task automatic run_cycle(
    input logic valid,
    input logic stall,
    input logic flush,
    input simd_mult_pkg::mult_op_t op,
    input simd_mult_pkg::simd_t a,
    input simd_mult_pkg::simd_t b,
    input simd_mult_pkg::simd_t c,
    input simd_mult_pkg::simd_t exp
);
    @(negedge clk);
    i_valid = valid;
    i_stall = stall;
    i_flush = flush;
    i_op = op;
    i_a = a;
    i_b = b;
    if (exp_q.size() > 0) begin
        i_c_late = c_q[0];  // stays put while stalled
    end else begin
        i_c_late = next_random();
    end
    #2;
    check_valid(o_valid, exp_q.size() > 0);
    if (exp_q.size() > 0) begin
        check_result(o_p, exp_q[0]);
    end
    if (flush) begin
        exp_q.delete();
        c_q.delete();
    end else if (!stall) begin
        if (exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            void'(c_q.pop_front());
        end
        if (valid) begin
            exp_q.push_back(exp);
            c_q.push_back(c);
        end
    end
endtask

initial begin
    logic [31:0] r;
    simd_mult_pkg::mult_op_t op;
    simd_mult_pkg::simd_t a;
    simd_mult_pkg::simd_t b;
    simd_mult_pkg::simd_t c;
    rng_state = 32'hdbae;
    i_reset = 1'b1;
    i_valid = 1'b1;  // an issue during reset must not show up
    i_stall = 1'b0;
    i_flush = 1'b0;
    i_op = simd_mult_pkg::MULT_OP_MUL;
    i_a = '0;
    i_b = '0;
    i_c_late = '0;
    $readmemh("sim/simd_mult_tests.txt", vec_mem, 0, n_vec*n_fields-1);
    repeat (2) @(posedge clk);
    @(negedge clk);
    i_reset = 1'b0;
    i_valid = 1'b0;
    #2;
    check_valid(o_valid, 1'b0);

    // directed vectors back to back
    for (int v = 0; v < n_vec; v++) begin
        run_cycle(1'b1, 1'b0, 1'b0, simd_mult_pkg::mult_op_t'(vec_mem[v*n_fields][2:0]),
                  vec_mem[v*n_fields+1], vec_mem[v*n_fields+2],
                  vec_mem[v*n_fields+3], vec_mem[v*n_fields+4]);
    end

    // flush drops the result in flight and idle gives no valid
    op = simd_mult_pkg::MULT_OP_DOT8;
    run_cycle(1'b1, 1'b0, 1'b0, op, 32'h01020304, 32'hfffefdfc, 32'h5,
              ref_result(op, 32'h01020304, 32'hfffefdfc, 32'h5));
    run_cycle(1'b1, 1'b0, 1'b1, op, 32'h11111111, 32'h22222222, 32'h0,
              ref_result(op, 32'h11111111, 32'h22222222, 32'h0));
    run_cycle(1'b0, 1'b0, 1'b0, op, '0, '0, '0, '0);
    run_cycle(1'b0, 1'b0, 1'b0, op, '0, '0, '0, '0);

    // random traffic with stalls, idles and the odd flush
    for (int n = 0; n < n_rand; n++) begin
        r = next_random();
        op = simd_mult_pkg::mult_op_t'(3'(r % 6));
        a = next_random();
        b = next_random();
        c = next_random();
        if (r[19:17] == 3'd0) a = 32'h80000000;
        if (r[16:14] == 3'd0) b = 32'hffffffff;
        run_cycle(r[27:25] != 3'd0, r[30:29] == 2'd0, r[24:20] == 5'd0,
                  op, a, b, c, ref_result(op, a, b, c));
    end
    run_cycle(1'b0, 1'b0, 1'b0, op, '0, '0, '0, '0);
    run_cycle(1'b0, 1'b0, 1'b0, op, '0, '0, '0, '0);

    $display("Simulation completed successfully");
    $finish;
end

endmodule

/* sim/simd_mult_tests.txt */
// columns: op a b c_late expected_p, all hex, one vector per line
// op: 0 mul, 1 mulh, 2 mulhsu, 3 mulhu, 4 dot16, 5 dot8
0 80000000 ffffffff 00000000 80000000
1 80000000 ffffffff 00000000 00000000
2 80000000 ffffffff 00000000 80000000
3 80000000 ffffffff 00000000 7fffffff
1 80000000 80000000 00000000 40000000
2 ffffffff ffffffff 00000000 ffffffff
3 ffffffff ffffffff 00000000 fffffffe
0 00010003 fffffffe 00000000 fffdfffa
2 7fffffff 80000000 00000000 3fffffff
0 ffffffff ffffffff 00000000 00000001
4 80008000 80008000 00000000 80000000
4 7fff8000 80007fff 00000010 80010010
4 0003fffe 00050007 ffffffff 00000000
5 80808080 80808080 00000000 ffff0000
5 7f01ff80 7f02037f 00000100 00000080

/* all.f */
logic/simd_mult_pkg.sv
logic/mult_stage_if.sv
logic/csa.sv
logic/csa_tree_8.sv
logic/simd_mult_core.sv
logic/mult_stage_ctrl.sv
logic/simd_mult_top.sv
sim/simd_mult_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module simd_mult_tb -f all.f -o simd_mult_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simd_mult_sim > "$log" 2>&1
status=$?
cat "$log"

# the testbench prints its fail line on any error or timeout
if grep -q "Simulation failed" "$log"; then
    echo "RESULT: FAIL"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
echo "RESULT: PASS"
exit 0
